// File: soc_bus_ctrl.sv
// Address decoder and response mux between the bus master and the four slaves.
`timescale 1ns/10ps

module soc_bus_ctrl (
    input  logic                        d_clk,
    input  logic                        d_rst,
    input  logic                        i_cyc,
    input  logic                        i_stb,
    input  logic                        i_we,
    input  soc_pkg::io_addr_t           i_adr,
    input  logic [soc_pkg::DATA_W-1:0]  i_dat,
    input  logic [soc_pkg::SEL_W-1:0]   i_sel,
    output logic [soc_pkg::DATA_W-1:0]  o_dat,
    output logic                        o_ack,
    output logic                        o_err,
    output logic                        o_ram_stb,
    output logic                        o_rom_stb,
    output logic                        o_tmr_stb,
    output logic                        o_irq_stb,
    output logic                        o_we,
    output logic [soc_pkg::DATA_W-1:0]  o_wdat,
    output logic [soc_pkg::SEL_W-1:0]   o_sel,
    output logic [3:0]                  o_reg_off,
    output logic [7:0]                  o_word_adr,
    input  logic [soc_pkg::DATA_W-1:0]  i_ram_dat,
    input  logic                        i_ram_ack,
    input  logic [soc_pkg::DATA_W-1:0]  i_rom_dat,
    input  logic                        i_rom_ack,
    input  logic [soc_pkg::DATA_W-1:0]  i_tmr_dat,
    input  logic                        i_tmr_ack,
    input  logic [soc_pkg::DATA_W-1:0]  i_irqc_dat,
    input  logic                        i_irqc_ack
);
    import soc_pkg::*;

    logic req;
    logic io_hit, ram_hit, rom_hit, tmr_hit, irqc_hit;
    logic err_q;

    assign req      = i_cyc & i_stb;
    assign io_hit   = (i_adr.io.page == IO_BASE[ADDR_W-1:8]);
    assign tmr_hit  = io_hit && (i_adr.io.dev == TIMER_PAGE[3:0]);
    assign irqc_hit = io_hit && (i_adr.io.dev == IRQC_PAGE[3:0]);
    assign ram_hit  = (i_adr.flat >= RAM_BASE) && (i_adr.flat <= RAM_END);
    assign rom_hit  = (i_adr.flat >= ROM_BASE) && (i_adr.flat <= ROM_END);

    assign o_ram_stb  = req & ram_hit;
    assign o_rom_stb  = req & rom_hit;
    assign o_tmr_stb  = req & tmr_hit;
    assign o_irq_stb  = req & irqc_hit;
    assign o_we       = i_cyc & i_we;                       // No write outside a cycle.
    assign o_wdat     = i_dat;
    assign o_sel      = i_sel;
    assign o_reg_off  = i_adr.io.off;
    assign o_word_adr = i_adr.flat[7:0];

    // Unmapped access, one-cycle pulse.
    always_ff @(posedge d_clk) begin
        if (d_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & ~(ram_hit | rom_hit | tmr_hit | irqc_hit) & ~err_q;
        end
    end

    assign o_err = err_q;

    always_comb begin
        o_dat = '0;
        o_ack = 1'b0;
        if (ram_hit) begin
            o_dat = i_ram_dat;
            o_ack = i_ram_ack;
        end else if (rom_hit) begin
            o_dat = i_rom_dat;
            o_ack = i_rom_ack;
        end else if (tmr_hit) begin
            o_dat = i_tmr_dat;
            o_ack = i_tmr_ack;
        end else if (irqc_hit) begin
            o_dat = i_irqc_dat;
            o_ack = i_irqc_ack;
        end
    end

    a_ack_err: assert property (@(posedge d_clk) disable iff (d_rst) !(o_ack && o_err));
    a_one_stb: assert property (@(posedge d_clk) disable iff (d_rst)
        $onehot0({o_ram_stb, o_rom_stb, o_tmr_stb, o_irq_stb}));

endmodule

// File: soc_irq_ctrl.sv
// Interrupt controller slave that latches line edges into pending and masks them onto one output.
`timescale 1ns/10ps

module soc_irq_ctrl (
    input  logic                        d_clk,
    input  logic                        d_rst,
    input  logic [soc_pkg::IRQ_N-1:0]   i_lines,
    input  logic                        i_stb,
    input  logic                        i_we,
    input  logic [3:0]                  i_off,
    input  logic [soc_pkg::DATA_W-1:0]  i_dat,
    output logic [soc_pkg::DATA_W-1:0]  o_dat,
    output logic                        o_ack,
    output logic                        o_irq
);
    import soc_pkg::*;

    logic [IRQ_N-1:0] lines_q;
    logic [IRQ_N-1:0] pending;
    logic [IRQ_N-1:0] mask;
    logic [IRQ_N-1:0] clr;
    logic             wr;

    assign wr  = i_stb & i_we & ~o_ack;
    assign clr = (wr && i_off == IRQ_PENDING) ? i_dat[IRQ_N-1:0] : '0;

    always_ff @(posedge d_clk) begin
        if (d_rst) begin
            lines_q <= '0;
            pending <= '0;
            mask    <= '0;
            o_irq   <= 1'b0;
            o_ack   <= 1'b0;
        end else begin
            o_ack   <= i_stb & ~o_ack;
            lines_q <= i_lines;
            pending <= (pending & ~clr) | (i_lines & ~lines_q);  // New edge beats clear.
            o_irq   <= |(pending & mask);
            if (wr && i_off == IRQ_MASK)
                mask <= i_dat[IRQ_N-1:0];
        end
    end

    always_ff @(posedge d_clk) begin
        if (i_stb && !o_ack) begin
            case (i_off)
                IRQ_PENDING: o_dat <= pending;
                IRQ_MASK:    o_dat <= mask;
                default:     o_dat <= '0;
            endcase
        end
    end

    // Output follows the masked pending set one clock later.
    a_irq_masked: assert property (@(posedge d_clk) disable iff (d_rst)
        !(|(pending & mask)) |=> !o_irq);

endmodule

// File: soc_pkg.sv
// Shared bus widths, address map, register offsets and boot image; import in every SoC module.

package soc_pkg;

    // ############################
    // Bus geometry
    // ############################
    localparam int ADDR_W = 24;
    localparam int DATA_W = 16;
    localparam int SEL_W  = 2;
    localparam int IRQ_N  = 16;                            // Line 0 is the timer.

    // ############################
    // Address map
    // ############################
    localparam logic [23:0] IO_BASE    = 24'h002000;       // 256-word I/O window.
    localparam logic [23:0] TIMER_PAGE = 24'h000000;
    localparam logic [23:0] IRQC_PAGE  = 24'h000001;
    localparam logic [23:0] RAM_BASE   = 24'h100000;
    localparam logic [23:0] RAM_END    = 24'h1000ff;
    localparam logic [23:0] ROM_BASE   = 24'hfffff0;
    localparam logic [23:0] ROM_END    = 24'hffffff;

    // Timer registers.
    localparam logic [3:0] TMR_COUNT  = 4'd0;              // Read only.
    localparam logic [3:0] TMR_RELOAD = 4'd1;
    localparam logic [3:0] TMR_CTRL   = 4'd2;              // Bit 0 is enable.

    // Interrupt controller registers.
    localparam logic [3:0] IRQ_PENDING = 4'd0;             // Write ones to clear.
    localparam logic [3:0] IRQ_MASK    = 4'd1;

    // Boot contents, word 0 at ROM_BASE.
    localparam logic [15:0] ROM_IMAGE [0:15] = '{
        16'h3c01, 16'h0020, 16'h3c02, 16'h0014,
        16'h5412, 16'h3c03, 16'h0001, 16'h5413,
        16'h3c04, 16'hffff, 16'h5424, 16'h7c00,
        16'h0000, 16'he00c, 16'ha5a5, 16'h5a5a
    };

    // One bus word seen flat for range checks, or split for I/O device selection.
    typedef struct packed {
        logic [15:0] page;
        logic [3:0]  dev;
        logic [3:0]  off;
    } io_split_t;

    typedef union packed {
        logic [ADDR_W-1:0] flat;
        io_split_t         io;
    } io_addr_t;

endpackage

// File: soc_ram.sv
// Scratch RAM slave of 256 words with byte-select writes, acknowledged one cycle after strobe.
`timescale 1ns/10ps

module soc_ram (
    input  logic                        d_clk,
    input  logic                        d_rst,
    input  logic                        i_stb,
    input  logic                        i_we,
    input  logic [soc_pkg::SEL_W-1:0]   i_sel,
    input  logic [7:0]                  i_adr,
    input  logic [soc_pkg::DATA_W-1:0]  i_dat,
    output logic [soc_pkg::DATA_W-1:0]  o_dat,
    output logic                        o_ack
);
    import soc_pkg::*;

    logic [DATA_W-1:0] mem [0:255];

    always_ff @(posedge d_clk) begin
        if (d_rst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb & ~o_ack;
        end
    end

    always_ff @(posedge d_clk) begin
        if (i_stb && !o_ack) begin
            o_dat <= mem[i_adr];
            if (i_we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (i_sel[b])
                        mem[i_adr][b*8 +: 8] <= i_dat[b*8 +: 8];  // Only selected lanes.
                end
            end
        end
    end

    a_ack_after_stb: assert property (@(posedge d_clk) disable iff (d_rst)
        o_ack |-> $past(i_stb));

endmodule

// File: soc_rom.sv
// Boot ROM slave serving the package image; writes are acknowledged and dropped.
`timescale 1ns/10ps

module soc_rom (
    input  logic                        d_clk,
    input  logic                        d_rst,
    input  logic                        i_stb,
    input  logic [3:0]                  i_adr,
    output logic [soc_pkg::DATA_W-1:0]  o_dat,
    output logic                        o_ack
);
    import soc_pkg::*;

    always_ff @(posedge d_clk) begin
        if (d_rst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb & ~o_ack;
        end
    end

    // Image word is captured with the strobe.
    always_ff @(posedge d_clk) begin
        if (i_stb && !o_ack)
            o_dat <= ROM_IMAGE[i_adr];
    end

endmodule

// File: soc_timer.sv
// Reload timer slave that counts down while enabled and pulses its interrupt on reload.
`timescale 1ns/10ps

module soc_timer (
    input  logic                        d_clk,
    input  logic                        d_rst,
    input  logic                        i_stb,
    input  logic                        i_we,
    input  logic [3:0]                  i_off,
    input  logic [soc_pkg::DATA_W-1:0]  i_dat,
    output logic [soc_pkg::DATA_W-1:0]  o_dat,
    output logic                        o_ack,
    output logic                        o_irq
);
    import soc_pkg::*;

    logic [DATA_W-1:0] count;
    logic [DATA_W-1:0] reload;
    logic              enable;
    logic              wr;
    logic [DATA_W-1:0] rd_dat;

    assign wr = i_stb & i_we & ~o_ack;                      // One write per access.

    always_comb begin
        case (i_off)
            TMR_COUNT:  rd_dat = count;
            TMR_RELOAD: rd_dat = reload;
            TMR_CTRL:   rd_dat = {{(DATA_W-1){1'b0}}, enable};
            default:    rd_dat = '0;
        endcase
    end

    always_ff @(posedge d_clk) begin
        if (d_rst) begin
            count  <= '0;
            reload <= '0;
            enable <= 1'b0;
            o_irq  <= 1'b0;
            o_ack  <= 1'b0;
        end else begin
            o_ack <= i_stb & ~o_ack;
            o_irq <= 1'b0;
            if (enable) begin
                if (count == '0) begin
                    count <= reload;
                    o_irq <= 1'b1;                          // Single-cycle pulse.
                end else begin
                    count <= count - 1'b1;
                end
            end
            if (wr && i_off == TMR_RELOAD) begin
                reload <= i_dat;
                count  <= i_dat;                            // Overrides the tick.
            end
            if (wr && i_off == TMR_CTRL)
                enable <= i_dat[0];
        end
    end

    always_ff @(posedge d_clk) begin
        if (i_stb && !o_ack)
            o_dat <= rd_dat;
    end

endmodule

// File: soc_top.sv
// SoC peripheral subsystem top; attach a bus master and external interrupt lines.
`timescale 1ns/10ps

module soc_top (
    input  logic                         d_clk,
    input  logic                         d_rst,
    input  logic                         i_cyc,
    input  logic                         i_stb,
    input  logic                         i_we,
    input  logic [soc_pkg::ADDR_W-1:0]   i_adr,
    input  logic [soc_pkg::DATA_W-1:0]   i_dat,
    input  logic [soc_pkg::SEL_W-1:0]    i_sel,
    input  logic [soc_pkg::IRQ_N-2:0]    i_ext_irq,
    output logic [soc_pkg::DATA_W-1:0]   o_dat,
    output logic                         o_ack,
    output logic                         o_err,
    output logic                         o_irq
);
    import soc_pkg::*;

    logic              ram_stb, rom_stb, tmr_stb, irqc_stb;
    logic              slv_we;
    logic [DATA_W-1:0] slv_wdat;
    logic [SEL_W-1:0]  slv_sel;
    logic [3:0]        reg_off;
    logic [7:0]        word_adr;
    logic [DATA_W-1:0] ram_dat, rom_dat, tmr_dat, irqc_dat;
    logic              ram_ack, rom_ack, tmr_ack, irqc_ack;
    logic              tmr_irq;
    logic [IRQ_N-1:0]  irq_lines;

    assign irq_lines = {i_ext_irq, tmr_irq};                // Timer on line 0.

    soc_bus_ctrl u_bus_ctrl (
        .d_clk(d_clk), .d_rst(d_rst),
        .i_cyc(i_cyc), .i_stb(i_stb), .i_we(i_we), .i_adr(i_adr),
        .i_dat(i_dat), .i_sel(i_sel),
        .o_dat(o_dat), .o_ack(o_ack), .o_err(o_err),
        .o_ram_stb(ram_stb), .o_rom_stb(rom_stb), .o_tmr_stb(tmr_stb), .o_irq_stb(irqc_stb),
        .o_we(slv_we), .o_wdat(slv_wdat), .o_sel(slv_sel),
        .o_reg_off(reg_off), .o_word_adr(word_adr),
        .i_ram_dat(ram_dat), .i_ram_ack(ram_ack),
        .i_rom_dat(rom_dat), .i_rom_ack(rom_ack),
        .i_tmr_dat(tmr_dat), .i_tmr_ack(tmr_ack),
        .i_irqc_dat(irqc_dat), .i_irqc_ack(irqc_ack)
    );

    soc_ram u_ram (
        .d_clk(d_clk), .d_rst(d_rst), .i_stb(ram_stb), .i_we(slv_we), .i_sel(slv_sel),
        .i_adr(word_adr), .i_dat(slv_wdat), .o_dat(ram_dat), .o_ack(ram_ack)
    );

    soc_rom u_rom (
        .d_clk(d_clk), .d_rst(d_rst), .i_stb(rom_stb), .i_adr(word_adr[3:0]),
        .o_dat(rom_dat), .o_ack(rom_ack)
    );

    soc_timer u_timer (
        .d_clk(d_clk), .d_rst(d_rst), .i_stb(tmr_stb), .i_we(slv_we), .i_off(reg_off),
        .i_dat(slv_wdat), .o_dat(tmr_dat), .o_ack(tmr_ack), .o_irq(tmr_irq)
    );

    soc_irq_ctrl u_irq_ctrl (
        .d_clk(d_clk), .d_rst(d_rst), .i_lines(irq_lines), .i_stb(irqc_stb),
        .i_we(slv_we), .i_off(reg_off), .i_dat(slv_wdat),
        .o_dat(irqc_dat), .o_ack(irqc_ack), .o_irq(o_irq)
    );

endmodule

// File: tb_soc_top.sv
// Table-driven testbench for the SoC peripheral subsystem; build with the file list, top tb_soc_top.
`timescale 1ns/10ps

module tb_soc_top;
    import soc_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 10;
    localparam int STEP_CYCLES = 64;
    localparam int MAX_STEPS   = 128;

    localparam logic [2:0] OP_WR    = 3'd0;
    localparam logic [2:0] OP_RD    = 3'd1;
    localparam logic [2:0] OP_IRQ   = 3'd2;                 // Wait for o_irq high.
    localparam logic [2:0] OP_QUIET = 3'd3;                 // o_irq must stay low.
    localparam logic [2:0] OP_EXT   = 3'd4;                 // Drive external lines.

    localparam logic [ADDR_W-1:0] TMR_ADR  = IO_BASE + TIMER_PAGE * 16;
    localparam logic [ADDR_W-1:0] IRQC_ADR = IO_BASE + IRQC_PAGE * 16;

    typedef struct packed {
        logic [2:0]        op;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
        logic [DATA_W-1:0] exp;
        logic              err;
    } step_t;

    logic              d_clk, d_rst;
    logic              i_cyc, i_stb, i_we;
    logic [ADDR_W-1:0] i_adr;
    logic [DATA_W-1:0] i_dat;
    logic [SEL_W-1:0]  i_sel;
    logic [IRQ_N-2:0]  i_ext_irq;
    logic [DATA_W-1:0] o_dat;
    logic              o_ack, o_err, o_irq;

    step_t             steps [0:MAX_STEPS-1];
    int                n_steps;
    logic [DATA_W-1:0] ram_model [0:255];
    integer            seed;
    bit                built;

    soc_top UUT (
        .d_clk(d_clk), .d_rst(d_rst), .i_cyc(i_cyc), .i_stb(i_stb), .i_we(i_we),
        .i_adr(i_adr), .i_dat(i_dat), .i_sel(i_sel), .i_ext_irq(i_ext_irq),
        .o_dat(o_dat), .o_ack(o_ack), .o_err(o_err), .o_irq(o_irq)
    );

    always #(CLK_PERIOD / 2) d_clk = ~d_clk;

    // ##############################
    // Reporting
    // ##############################
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h at %0t",
                               name, got, exp, $time));
    endtask

    // ##############################
    // Stimulus table
    // ##############################
    task automatic add_step(input logic [2:0] op, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                            input logic [DATA_W-1:0] exp, input logic err);
        steps[n_steps] = {op, adr, dat, sel, exp, err};
        n_steps++;
    endtask

    task automatic build_table();
        logic [7:0]        ram_adr [0:7];
        logic [DATA_W-1:0] d;
        logic [SEL_W-1:0]  s;
        integer            r;
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            ram_adr[k] = r[7:0];
            d = $random(seed);
            add_step(OP_WR, RAM_BASE + ram_adr[k], d, 2'b11, '0, 1'b0);
            ram_model[ram_adr[k]] = d;
        end
        for (int k = 0; k < 8; k++) begin
            d = $random(seed);
            s = (k % 2) ? 2'b10 : 2'b01;                    // Alternate byte lanes.
            add_step(OP_WR, RAM_BASE + ram_adr[k], d, s, '0, 1'b0);
            if (s[0])
                ram_model[ram_adr[k]][7:0] = d[7:0];
            if (s[1])
                ram_model[ram_adr[k]][15:8] = d[15:8];
        end
        for (int k = 0; k < 8; k++)
            add_step(OP_RD, RAM_BASE + ram_adr[k], '0, 2'b11, ram_model[ram_adr[k]], 1'b0);
        for (int k = 0; k < 16; k++)
            add_step(OP_RD, ROM_BASE + k, '0, 2'b11, ROM_IMAGE[k], 1'b0);
        add_step(OP_WR, ROM_BASE + 5, 16'h1234, 2'b11, '0, 1'b0);
        add_step(OP_RD, ROM_BASE + 5, '0, 2'b11, ROM_IMAGE[5], 1'b0);
        add_step(OP_RD, 24'h000000, '0, 2'b11, '0, 1'b1);   // Unmapped space.
        add_step(OP_RD, 24'h003000, '0, 2'b11, '0, 1'b1);
        add_step(OP_RD, IO_BASE + 24'h20, '0, 2'b11, '0, 1'b1);
        add_step(OP_WR, 24'h0fffff, 16'hdead, 2'b11, '0, 1'b1);
        add_step(OP_WR, TMR_ADR + TMR_RELOAD, 16'd20, 2'b11, '0, 1'b0);
        add_step(OP_RD, TMR_ADR + TMR_RELOAD, '0, 2'b11, 16'd20, 1'b0);
        add_step(OP_RD, TMR_ADR + TMR_CTRL, '0, 2'b11, 16'h0000, 1'b0);
        add_step(OP_WR, IRQC_ADR + IRQ_MASK, 16'h0001, 2'b11, '0, 1'b0);
        add_step(OP_WR, TMR_ADR + TMR_CTRL, 16'h0001, 2'b11, '0, 1'b0);
        add_step(OP_IRQ, '0, '0, '0, '0, 1'b0);
        add_step(OP_RD, IRQC_ADR + IRQ_PENDING, '0, 2'b11, 16'h0001, 1'b0);
        add_step(OP_WR, TMR_ADR + TMR_CTRL, 16'h0000, 2'b11, '0, 1'b0);
        add_step(OP_WR, IRQC_ADR + IRQ_PENDING, 16'h0001, 2'b11, '0, 1'b0);
        add_step(OP_RD, IRQC_ADR + IRQ_PENDING, '0, 2'b11, 16'h0000, 1'b0);
        add_step(OP_QUIET, '0, '0, '0, '0, 1'b0);
        add_step(OP_EXT, '0, 16'h0008, '0, '0, 1'b0);       // Line 4 while masked.
        add_step(OP_QUIET, '0, '0, '0, '0, 1'b0);
        add_step(OP_RD, IRQC_ADR + IRQ_PENDING, '0, 2'b11, 16'h0010, 1'b0);
        add_step(OP_WR, IRQC_ADR + IRQ_MASK, 16'h0011, 2'b11, '0, 1'b0);
        add_step(OP_IRQ, '0, '0, '0, '0, 1'b0);
        add_step(OP_WR, IRQC_ADR + IRQ_PENDING, 16'h0010, 2'b11, '0, 1'b0);
        add_step(OP_QUIET, '0, '0, '0, '0, 1'b0);
        add_step(OP_EXT, '0, 16'h0000, '0, '0, 1'b0);
        add_step(OP_RD, IRQC_ADR + IRQ_PENDING, '0, 2'b11, 16'h0000, 1'b0);
    endtask

    // ##############################
    // Bus and interrupt actions
    // ##############################
    task automatic bus_access(input step_t s);
        int                n;
        logic [DATA_W-1:0] got_dat;
        logic              got_ack, got_err;
        n = 0;
        @(posedge d_clk);
        i_cyc <= 1'b1;
        i_stb <= 1'b1;
        i_we  <= (s.op == OP_WR);
        i_adr <= s.adr;
        i_dat <= s.dat;
        i_sel <= s.sel;
        @(negedge d_clk);
        check_value("o_ack in strobe cycle", o_ack, 1'b0);  // No response before one cycle.
        check_value("o_err in strobe cycle", o_err, 1'b0);
        do begin
            @(posedge d_clk);
            n++;
            @(negedge d_clk);
            if (n > 16)
                fail_run($sformatf("No ack or err for access to 0x%06h.", s.adr));
        end while (!(o_ack || o_err));
        got_dat = o_dat;
        got_ack = o_ack;
        got_err = o_err;
        check_value("latency", n, 1);
        check_value($sformatf("o_err @0x%06h", s.adr), got_err, s.err);
        check_value($sformatf("o_ack @0x%06h", s.adr), got_ack, !s.err);
        if (s.op == OP_RD && !s.err)
            check_value($sformatf("o_dat @0x%06h", s.adr), got_dat, s.exp);
        @(posedge d_clk);
        i_cyc <= 1'b0;
        i_stb <= 1'b0;
        i_we  <= 1'b0;
        @(negedge d_clk);
        check_value("o_ack after pulse", o_ack, 1'b0);  // Single-cycle response.
        check_value("o_err after pulse", o_err, 1'b0);
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (o_irq !== 1'b1) begin
            @(negedge d_clk);
            n++;
            if (n > 48)
                fail_run("Interrupt output did not rise in time.");
        end
    endtask

    task automatic hold_quiet();
        repeat (4) begin
            @(negedge d_clk);
            check_value("o_irq", o_irq, 1'b0);
        end
    endtask

    task automatic drive_ext(input logic [IRQ_N-2:0] lines);
        @(posedge d_clk);
        i_ext_irq <= lines;
    endtask

    initial begin
        wait (built);
        #((n_steps * STEP_CYCLES + RST_CYCLES) * CLK_PERIOD);
        fail_run("Watchdog expired before the test table finished.");
    end

    initial begin
        seed      = 32'he1890ecb;
        d_clk     = 1'b0;
        d_rst     = 1'b1;
        i_cyc     = 1'b0;
        i_stb     = 1'b0;
        i_we      = 1'b0;
        i_adr     = '0;
        i_dat     = '0;
        i_sel     = '0;
        i_ext_irq = '0;
        n_steps   = 0;
        build_table();
        built = 1'b1;
        repeat (RST_CYCLES) @(posedge d_clk);
        d_rst <= 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            case (steps[i].op)
                OP_WR, OP_RD: bus_access(steps[i]);
                OP_IRQ:       wait_irq();
                OP_QUIET:     hold_quiet();
                default:      drive_ext(steps[i].dat[IRQ_N-2:0]);
            endcase
        end
        repeat (2) @(posedge d_clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: verilog.f
soc_pkg.sv
soc_ram.sv
soc_rom.sv
soc_timer.sv
soc_irq_ctrl.sv
soc_bus_ctrl.sv
soc_top.sv
tb_soc_top.sv
